// File: cla_adder.sv
`timescale 1ns/10ps

module cla_adder #(
    parameter int WIDTH = 32,
    parameter int GROUP = 4
) (
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    output logic [WIDTH-1:0] sum
);

    localparam int NUM_GROUPS = (WIDTH + GROUP - 1) / GROUP;

    logic [WIDTH-1:0] gen;
    logic [WIDTH-1:0] prop;
    logic [WIDTH-1:0] carry;
    // carry into each group, rippled from the group below
    logic [NUM_GROUPS-1:0] group_carry;

    assign gen = a & b;
    assign prop = a ^ b;

    always_comb begin
        logic group_gen;
        logic group_prop;
        int idx;
        carry = '0;
        group_carry = '0;
        for (int grp = 0; grp < NUM_GROUPS; grp++) begin
            group_gen = 1'b0;
            group_prop = 1'b1;
            for (int k = 0; k < GROUP; k++) begin
                idx = grp * GROUP + k;
                if (idx < WIDTH) begin
                    // lookahead from the group carry-in
                    carry[idx] = group_gen | (group_prop & group_carry[grp]);
                    group_gen = gen[idx] | (prop[idx] & group_gen);
                    group_prop = group_prop & prop[idx];
                end
            end
            if (grp + 1 < NUM_GROUPS) begin
                group_carry[grp + 1] = group_gen | (group_prop & group_carry[grp]);
            end
        end
    end

    assign sum = prop ^ carry;

endmodule

// File: dadda_multiplier.sv
`timescale 1ns/10ps

module dadda_multiplier #(
    parameter int TREE_REG_STAGE = 3,
    parameter int ADDER_GROUP = 4
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              in_valid,
    output logic              in_ready,
    input  mul_pkg::mul_req_t in_req,
    output logic              out_valid,
    input  logic              out_ready,
    output mul_pkg::mul_rsp_t out_rsp
);

    logic                   req_valid;
    logic                   req_ready;
    mul_pkg::mul_req_t      req;
    dadda_pkg::bit_matrix_t pp_matrix;
    logic                   rows_valid;
    logic                   rows_ready;
    dadda_pkg::tree_out_t   tree_rows;
    logic                   add_valid;
    logic                   add_ready;
    dadda_pkg::tree_out_t   add_rows;
    mul_pkg::product_t      product;
    mul_pkg::mul_rsp_t      rsp;

    // s0 operand slice
    pipe_reg #(.payload_t(mul_pkg::mul_req_t)) u_s0 (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_req),
        .out_valid (req_valid),
        .out_ready (req_ready),
        .out_data  (req)
    );

    partial_products u_pp (
        .req    (req),
        .matrix (pp_matrix)
    );

    // holds slice s1 inside
    dadda_tree #(.REG_AFTER_STAGE(TREE_REG_STAGE)) u_tree (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (req_valid),
        .in_ready  (req_ready),
        .matrix    (pp_matrix),
        .out_valid (rows_valid),
        .out_ready (rows_ready),
        .rows      (tree_rows)
    );

    // s2 holds the two rows
    pipe_reg #(.payload_t(dadda_pkg::tree_out_t)) u_s2 (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (rows_valid),
        .in_ready  (rows_ready),
        .in_data   (tree_rows),
        .out_valid (add_valid),
        .out_ready (add_ready),
        .out_data  (add_rows)
    );

    cla_adder #(
        .WIDTH (mul_pkg::PRODUCT_WIDTH),
        .GROUP (ADDER_GROUP)
    ) u_cla (
        .a   (add_rows.row_sum),
        .b   (add_rows.row_carry),
        .sum (product)
    );

    assign rsp.product = product;

    // s3 output slice
    pipe_reg #(.payload_t(mul_pkg::mul_rsp_t)) u_s3 (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (add_valid),
        .in_ready  (add_ready),
        .in_data   (rsp),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_rsp)
    );

endmodule

// File: dadda_pkg.sv
package dadda_pkg;

    localparam int NUM_STAGES = 6;

    // column-indexed partial product bits, row 0 at the bottom
    typedef logic [mul_pkg::PRODUCT_WIDTH-1:0][mul_pkg::OPERAND_WIDTH-1:0] bit_matrix_t;

    // the two rows left for the final adder
    typedef struct packed {
        mul_pkg::product_t row_sum;
        mul_pkg::product_t row_carry;
    } tree_out_t;

    // dadda sequence 2, 3, 4, 6, 9, 13 read from the top down
    function automatic int height_for_stage(int stage);
        int height;
        height = 2;
        for (int i = 0; i < NUM_STAGES - 1 - stage; i++) begin
            height = (height * 3) / 2;
        end
        return height;
    endfunction

    // adders needed in a column holding total bits, which is also its carry count
    function automatic int column_adders(int total, int target);
        return (total > target) ? (total - target + 1) / 2 : 0;
    endfunction

    // bits a column holds at the input of the given stage
    function automatic int column_height(int col, int stage);
        int height [mul_pkg::PRODUCT_WIDTH];
        int carry;
        int total;
        int target;
        for (int c = 0; c < mul_pkg::PRODUCT_WIDTH; c++) begin
            height[c] = (c < mul_pkg::OPERAND_WIDTH) ? c + 1 : 2 * mul_pkg::OPERAND_WIDTH - 1 - c;
        end
        for (int s = 0; s < stage; s++) begin
            target = height_for_stage(s);
            carry = 0;
            for (int c = 0; c < mul_pkg::PRODUCT_WIDTH; c++) begin
                total = height[c] + carry;
                carry = column_adders(total, target);
                height[c] = (total > target) ? target : total;
            end
        end
        return height[col];
    endfunction

    // carries arriving in a column from the one below during the given stage
    function automatic int column_carry_in(int col, int stage);
        int carry;
        int total;
        carry = 0;
        for (int c = 0; c < col; c++) begin
            total = column_height(c, stage) + carry;
            carry = column_adders(total, height_for_stage(stage));
        end
        return carry;
    endfunction

endpackage

// File: dadda_stage.sv
`timescale 1ns/10ps

module dadda_stage #(
    parameter int STAGE = 0
) (
    input  dadda_pkg::bit_matrix_t matrix_in,
    output dadda_pkg::bit_matrix_t matrix_out
);

    localparam int COLUMNS = mul_pkg::PRODUCT_WIDTH;
    localparam int DEPTH = mul_pkg::OPERAND_WIDTH;
    localparam int TARGET = dadda_pkg::height_for_stage(STAGE);

    // carry out of adder k in column col goes to column col+1
    logic [COLUMNS-1:0][DEPTH-1:0] carry;

    for (genvar col = 0; col < COLUMNS; col++) begin : g_col
        localparam int H_IN = dadda_pkg::column_height(col, STAGE);
        localparam int C_IN = dadda_pkg::column_carry_in(col, STAGE);
        localparam int EXCESS = (H_IN + C_IN > TARGET) ? H_IN + C_IN - TARGET : 0;
        localparam int N_FA = EXCESS / 2;
        localparam int N_HA = EXCESS % 2;
        localparam int N_ADD = N_FA + N_HA;
        localparam int USED = 3 * N_FA + 2 * N_HA;
        localparam int N_PASS = H_IN - USED;
        localparam int H_OUT = N_PASS + N_ADD + C_IN;

        // full adders take the lowest bits, three at a time
        for (genvar k = 0; k < N_FA; k++) begin : g_fa
            logic x;
            logic y;
            logic z;
            assign x = matrix_in[col][3 * k];
            assign y = matrix_in[col][3 * k + 1];
            assign z = matrix_in[col][3 * k + 2];
            assign matrix_out[col][N_PASS + k] = x ^ y ^ z;
            assign carry[col][k] = (x & y) | (z & (x ^ y));
        end

        if (N_HA == 1) begin : g_ha
            logic x;
            logic y;
            assign x = matrix_in[col][3 * N_FA];
            assign y = matrix_in[col][3 * N_FA + 1];
            assign matrix_out[col][N_PASS + N_FA] = x ^ y;
            assign carry[col][N_FA] = x & y;
        end

        for (genvar k = N_ADD; k < DEPTH; k++) begin : g_no_carry
            assign carry[col][k] = 1'b0;
        end

        // untouched bits move down to the bottom rows
        for (genvar k = 0; k < N_PASS; k++) begin : g_pass
            assign matrix_out[col][k] = matrix_in[col][USED + k];
        end

        for (genvar k = 0; k < C_IN; k++) begin : g_carry_in
            assign matrix_out[col][N_PASS + N_ADD + k] = carry[col - 1][k];
        end

        for (genvar k = H_OUT; k < DEPTH; k++) begin : g_empty
            assign matrix_out[col][k] = 1'b0;
        end
    end

endmodule

// File: dadda_tree.sv
`timescale 1ns/10ps

module dadda_tree #(
    parameter int REG_AFTER_STAGE = 3
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  dadda_pkg::bit_matrix_t matrix,
    output logic                   out_valid,
    input  logic                   out_ready,
    output dadda_pkg::tree_out_t   rows
);

    localparam int STAGES = dadda_pkg::NUM_STAGES;

    dadda_pkg::bit_matrix_t stage_in [STAGES];
    dadda_pkg::bit_matrix_t stage_out [STAGES];
    dadda_pkg::bit_matrix_t held;
    dadda_pkg::bit_matrix_t final_matrix;

    // heights 13, 9, 6, 4, 3, 2
    for (genvar s = 0; s < STAGES; s++) begin : g_stage
        if (s == 0) begin : g_first
            assign stage_in[s] = matrix;
        end else if (s == REG_AFTER_STAGE + 1) begin : g_after_reg
            assign stage_in[s] = held;
        end else begin : g_chain
            assign stage_in[s] = stage_out[s - 1];
        end

        dadda_stage #(.STAGE(s)) u_stage (
            .matrix_in  (stage_in[s]),
            .matrix_out (stage_out[s])
        );
    end

    pipe_reg #(.payload_t(dadda_pkg::bit_matrix_t)) u_s1 (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (stage_out[REG_AFTER_STAGE]),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (held)
    );

    if (REG_AFTER_STAGE == STAGES - 1) begin : g_reg_last
        assign final_matrix = held;
    end else begin : g_reg_inside
        assign final_matrix = stage_out[STAGES - 1];
    end

    // two rows remain after the last stage
    always_comb begin
        for (int col = 0; col < mul_pkg::PRODUCT_WIDTH; col++) begin
            rows.row_sum[col] = final_matrix[col][0];
            rows.row_carry[col] = final_matrix[col][1];
        end
    end

endmodule

// File: mul_pkg.sv
package mul_pkg;

    // operand and product sizes
    localparam int OPERAND_WIDTH = 16;
    localparam int PRODUCT_WIDTH = 2 * OPERAND_WIDTH;

    typedef logic [OPERAND_WIDTH-1:0] operand_t;
    typedef logic [PRODUCT_WIDTH-1:0] product_t;

    // one operand pair on the input stream
    typedef struct packed {
        operand_t a;
        operand_t b;
    } mul_req_t;

    // one product on the output stream
    typedef struct packed {
        product_t product;
    } mul_rsp_t;

endpackage

// File: partial_products.sv
`timescale 1ns/10ps

module partial_products (
    input  mul_pkg::mul_req_t      req,
    output dadda_pkg::bit_matrix_t matrix
);

    localparam int COLUMNS = mul_pkg::PRODUCT_WIDTH;
    localparam int DEPTH = mul_pkg::OPERAND_WIDTH;

    for (genvar col = 0; col < COLUMNS; col++) begin : g_col
        localparam int HEIGHT = dadda_pkg::column_height(col, 0);
        // lowest bit index of a that lands in this column
        localparam int A_LOW = (col < DEPTH) ? 0 : col - DEPTH + 1;

        for (genvar row = 0; row < DEPTH; row++) begin : g_row
            if (row < HEIGHT) begin : g_bit
                assign matrix[col][row] = req.a[A_LOW + row] & req.b[col - A_LOW - row];
            end else begin : g_empty
                assign matrix[col][row] = 1'b0;
            end
        end
    end

endmodule

// File: pipe_reg.sv
`timescale 1ns/10ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    // free when empty or when the held item leaves this cycle
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_ready && in_valid) begin
            out_data <= in_data;
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_dadda_multiplier -o tb_sim
./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
if ! grep -q "Simulation passed" sim.log; then
    echo "no pass message in sim.log"
    exit 1
fi

// File: tb_dadda_multiplier.sv
`timescale 1ns/10ps

module tb_dadda_multiplier;

    localparam int CLK_PERIOD = 4;
    localparam int LATENCY = 4;
    localparam int NUM_RANDOM = 2000;
    localparam int NUM_CORNER = 21;
    localparam int NUM_STREAM = 200;
    localparam int NUM_STALL = 2000;
    localparam int NUM_OPS = NUM_RANDOM + NUM_CORNER * NUM_CORNER + NUM_STREAM + NUM_STALL;
    // cycles allowed per operation including back-pressure
    localparam int STALL_BOUND = 16;
    localparam int WATCHDOG_NS = (NUM_OPS * STALL_BOUND + 500) * CLK_PERIOD;

    logic              clk;
    logic              reset;
    logic              in_valid;
    logic              in_ready;
    mul_pkg::mul_req_t in_req;
    logic              out_valid;
    logic              out_ready;
    mul_pkg::mul_rsp_t out_rsp;

    integer            seed;
    int                cycle;
    int                accept_count;
    int                out_count;
    int                last_out_cycle;
    bit                timing_mode;
    bit                random_ready;
    bit                stall_pending;
    mul_pkg::mul_rsp_t held_rsp;
    mul_pkg::mul_rsp_t expected_q [$];
    int                accept_time_q [$];

    dadda_multiplier UUT (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_req    (in_req),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_rsp   (out_rsp)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_rsp(input string name, input mul_pkg::mul_rsp_t got,
                             input mul_pkg::mul_rsp_t exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch at %0t ns: %s got %h expected %h",
                                     $time, name, got.product, exp.product));
        end
    endtask

    task automatic check_latency(input string name, input int got, input int exp);
        if (got != exp) begin
            report_failure($sformatf("Mismatch at %0t ns: %s got %0d expected %0d cycles",
                                     $time, name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch at %0t ns: %s got %b expected %b",
                                     $time, name, got, exp));
        end
    endtask

    // plain unsigned multiply at full product width
    function automatic mul_pkg::mul_rsp_t model_product(input mul_pkg::mul_req_t req);
        mul_pkg::mul_rsp_t rsp;
        rsp.product = mul_pkg::product_t'(req.a) * mul_pkg::product_t'(req.b);
        return rsp;
    endfunction

    function automatic mul_pkg::operand_t random_operand();
        logic [31:0] r;
        r = $random(seed);
        return r[15:0];
    endfunction

    // zero, one, all ones, alternating, then the 16 single set bits
    function automatic mul_pkg::operand_t corner_operand(input int idx);
        mul_pkg::operand_t value;
        case (idx)
            0: value = 16'h0000;
            1: value = 16'h0001;
            2: value = 16'hffff;
            3: value = 16'haaaa;
            4: value = 16'h5555;
            default: value = mul_pkg::operand_t'(1) << (idx - 5);
        endcase
        return value;
    endfunction

    task automatic toggle_ready();
        logic [31:0] r;
        if (random_ready) begin
            r = $random(seed);
            out_ready = r[0];
        end
    endtask

    // starts on a falling edge and returns on the one after the accept
    task automatic send_item(input mul_pkg::mul_req_t req, input bit gaps);
        int target;
        target = accept_count + 1;
        while (gaps && (($random(seed) & 3) == 0)) begin
            in_valid = 1'b0;
            @(negedge clk);
            toggle_ready();
        end
        in_valid = 1'b1;
        in_req = req;
        while (accept_count < target) begin
            @(negedge clk);
            toggle_ready();
        end
        in_valid = 1'b0;
    endtask

    task automatic drain();
        while (expected_q.size() != 0) begin
            @(negedge clk);
            toggle_ready();
        end
    endtask

    // stream monitor and scoreboard
    always @(posedge clk) begin
        mul_pkg::mul_rsp_t expected;
        int accepted_at;
        cycle = cycle + 1;
        if (!reset) begin
            if (timing_mode && in_valid && !in_ready) begin
                report_failure("in_ready went low while out_ready was held high");
            end
            if (in_valid && in_ready) begin
                expected_q.push_back(model_product(in_req));
                accept_time_q.push_back(cycle);
                accept_count = accept_count + 1;
            end
            if (stall_pending) begin
                check_flag("out_valid", out_valid, 1'b1);
                check_rsp("out_rsp", out_rsp, held_rsp);
            end
            if (out_valid && out_ready) begin
                if (expected_q.size() == 0) begin
                    report_failure("a product came out with no operands pending");
                end else begin
                    expected = expected_q.pop_front();
                    accepted_at = accept_time_q.pop_front();
                    check_rsp("out_rsp", out_rsp, expected);
                    if (timing_mode) begin
                        check_latency("latency", cycle - accepted_at, LATENCY);
                    end
                    out_count = out_count + 1;
                    last_out_cycle = cycle;
                end
            end
            stall_pending = out_valid && !out_ready;
            held_rsp = out_rsp;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: outputs stopped arriving after %0d products", out_count);
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        mul_pkg::mul_req_t req;
        int start_cycle;
        seed = 89;
        clk = 1'b0;
        reset = 1'b1;
        in_valid = 1'b0;
        in_req = '0;
        out_ready = 1'b1;
        cycle = 0;
        accept_count = 0;
        out_count = 0;
        last_out_cycle = 0;
        timing_mode = 1'b0;
        random_ready = 1'b0;
        stall_pending = 1'b0;
        held_rsp = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_flag("out_valid", out_valid, 1'b0);
        check_flag("in_ready", in_ready, 1'b1);

        timing_mode = 1'b1;
        for (int n = 0; n < NUM_RANDOM; n++) begin
            req.a = random_operand();
            req.b = random_operand();
            send_item(req, 1'b0);
        end
        for (int i = 0; i < NUM_CORNER; i++) begin
            for (int j = 0; j < NUM_CORNER; j++) begin
                req.a = corner_operand(i);
                req.b = corner_operand(j);
                send_item(req, 1'b0);
            end
        end
        drain();

        // back-to-back stream into an empty pipeline at one product per cycle
        start_cycle = cycle;
        for (int n = 0; n < NUM_STREAM; n++) begin
            req.a = random_operand();
            req.b = random_operand();
            send_item(req, 1'b0);
        end
        drain();
        check_latency("stream span", last_out_cycle - start_cycle, NUM_STREAM + LATENCY);

        timing_mode = 1'b0;
        random_ready = 1'b1;
        for (int n = 0; n < NUM_STALL; n++) begin
            req.a = random_operand();
            req.b = random_operand();
            send_item(req, 1'b1);
        end
        drain();
        random_ready = 1'b0;
        out_ready = 1'b1;
        // idle long enough for any extra product to reach the monitor
        repeat (2 * LATENCY) @(negedge clk);

        if (!out_valid && in_ready && out_count == NUM_OPS) begin
            $display("Simulation passed");
            $finish;
        end else begin
            report_failure("pipeline not idle or products missing at the end of the run");
        end
    end

endmodule

// File: vlog.f
mul_pkg.sv
dadda_pkg.sv
pipe_reg.sv
partial_products.sv
dadda_stage.sv
cla_adder.sv
dadda_tree.sv
dadda_multiplier.sv
tb_dadda_multiplier.sv
